// File: flist.f
verilog/meterPkg.sv
verilog/buttonEdges.sv
verilog/secondTicker.sv
verilog/bcdTimeKeeper.sv
verilog/segmentDriver.sv
verilog/parkingMeter.sv
sim/parkingMeterTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the parking meter testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--timescale 1ns/100ps \
	--top-module parkingMeterTb \
	-Mdir obj_dir \
	-f flist.f

./obj_dir/VparkingMeterTb | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"

// File: sim/parkingMeterTb.sv
`default_nettype none
`timescale 1ns/100ps

module parkingMeterTb;

	import meterPkg::*;

	localparam int TickClocks    = 16;
	localparam int ResetCycles   = 10;
	localparam int RandomPresses = 50;
	localparam int FillPresses   = 21; // 20 five-minute adds already pass 99:59 from zero
	localparam int SegmentRounds = 15;
	localparam int MaxSeconds    = 99 * 60 + 59;
	// sum of the test lengths plus a margin
	localparam int TimeoutCycles = ResetCycles + 40 + 6 * 10 + 10 + RandomPresses * 8
		+ FillPresses * 4 + 90 * TickClocks + 3 * (TickClocks + 4) + SegmentRounds * 60
		+ 300;

	logic        clock;
	logic        reset;
	logic [5:0]  buttons; // bit 0 has the highest priority
	meterTimeT   remaining;
	logic        expired;
	segmentBankT segments;

	int errorCount    = 0;
	int errorsAtStart = 0;
	int testsRun      = 0;
	int testsFailed   = 0;
	int cycleCount    = 0;

	parkingMeter #(
		.SecondDivisor (TickClocks)
	) parkingMeter_i (
		.clock         (clock),
		.reset         (reset),
		.addOne        (buttons[2]),
		.addTwo        (buttons[3]),
		.addThree      (buttons[4]),
		.addFive       (buttons[5]),
		.presetShortIn (buttons[0]),
		.presetLongIn  (buttons[1]),
		.remaining     (remaining),
		.expired       (expired),
		.segments      (segments)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////
	// reference model

	function automatic int buttonAmount(input int index);
		case (index)
			0:       return 15;  // 00:15 preset
			1:       return 150; // 02:30 preset
			2:       return 60;
			3:       return 120;
			4:       return 180;
			default: return 300;
		endcase
	endfunction

	// lowest index wins, -1 for none
	function automatic int firstRising(input logic [5:0] rising);
		int index;
		index = -1;
		for (int i = 5; i >= 0; i--)
			if (rising[i])
				index = i;
		return index;
	endfunction

	function automatic meterTimeT toBcd(input int seconds);
		int        minutes;
		int        secs;
		meterTimeT bcd;
		minutes = seconds / 60;
		secs = seconds % 60;
		bcd.minTens = 4'(minutes / 10);
		bcd.minOnes = 4'(minutes % 10);
		bcd.secTens = 4'(secs / 10);
		bcd.secOnes = 4'(secs % 10);
		return bcd;
	endfunction

	// lit segments a..g, then inverted for the active-low display
	function automatic segmentT digitPattern(input bcdDigitT digit);
		logic [6:0] lit;
		case (digit)
			4'd1:    lit = 7'b0110000;
			4'd2:    lit = 7'b1101101;
			4'd3:    lit = 7'b1111001;
			4'd4:    lit = 7'b0110011;
			4'd5:    lit = 7'b1011011;
			4'd6:    lit = 7'b1011111;
			4'd7:    lit = 7'b1110000;
			4'd8:    lit = 7'b1111111;
			4'd9:    lit = 7'b1111011;
			default: lit = 7'b1111110; // zero
		endcase
		return ~lit;
	endfunction

	int         edgeCount;
	int         modelSeconds;
	int         pendingSeconds;
	int         modelPick;
	logic       modelTick;
	logic       modelPhase;
	logic       pendingValid;
	logic       pendingPreset;
	logic [5:0] prevButtons;

	always @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			edgeCount <= 0;
			modelSeconds <= 0;
			pendingSeconds <= 0;
			modelTick <= 1'b0;
			modelPhase <= 1'b0;
			pendingValid <= 1'b0;
			pendingPreset <= 1'b0;
			prevButtons <= '0;
		end
		else
		begin
			modelPick = firstRising(buttons & ~prevButtons);
			edgeCount <= edgeCount + 1;
			modelTick <= ((edgeCount + 1) % TickClocks == 0); // every 16th clock
			if ((edgeCount + 1) % TickClocks == 0)
				modelPhase <= ~modelPhase;
			prevButtons <= buttons;
			pendingValid <= (modelPick >= 0);
			pendingPreset <= (modelPick == 0 || modelPick == 1);
			pendingSeconds <= (modelPick >= 0) ? buttonAmount(modelPick) : 0;
			if (pendingValid)
			begin
				if (pendingPreset)
					modelSeconds <= pendingSeconds;
				else if (modelSeconds + pendingSeconds > MaxSeconds)
					modelSeconds <= MaxSeconds; // saturate
				else
					modelSeconds <= modelSeconds + pendingSeconds;
			end
			else if (modelTick && modelSeconds > 0)
				modelSeconds <= modelSeconds - 1; // tick lost under a request
		end
	end

	meterTimeT   expectTime;
	logic        expectExpired;
	segmentBankT expectSegments;

	always_comb
	begin
		expectTime = toBcd(modelSeconds);
		expectExpired = (modelSeconds == 0);
		if (expectExpired && modelPhase)
			expectSegments = '1;
		else
		begin
			expectSegments.minTens = digitPattern(expectTime.minTens);
			expectSegments.minOnes = digitPattern(expectTime.minOnes);
			expectSegments.secTens = digitPattern(expectTime.secTens);
			expectSegments.secOnes = digitPattern(expectTime.secOnes);
		end
	end

	////////////////////
	// checks, mid-cycle

	remainingCheck: assert property (@(negedge clock) disable iff (reset)
		remaining == expectTime)
	else
	begin
		$display("[ERROR] time %0d ns: remaining %h, expected %h", $time, remaining, expectTime);
		errorCount = errorCount + 1;
	end

	expiredCheck: assert property (@(negedge clock) disable iff (reset)
		expired == expectExpired)
	else
	begin
		$display("[ERROR] time %0d ns: expired %b, expected %b", $time, expired, expectExpired);
		errorCount = errorCount + 1;
	end

	segmentCheck: assert property (@(negedge clock) disable iff (reset)
		segments == expectSegments)
	else
	begin
		$display("[ERROR] time %0d ns: segments %h, expected %h", $time, segments,
			expectSegments);
		errorCount = errorCount + 1;
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// stimulus

	task automatic pressButtons(input logic [5:0] mask, input int holdCycles);
		@(posedge clock);
		buttons <= mask;
		repeat (holdCycles) @(posedge clock);
		buttons <= '0;
		@(posedge clock); // one low sample before the next press
	endtask

	// drive once the edge count reaches the given phase of the tick period
	task automatic pressOnPhase(input logic [5:0] mask, input int phase);
		@(posedge clock);
		while (edgeCount % TickClocks != phase)
			@(posedge clock);
		buttons <= mask;
		@(posedge clock);
		buttons <= '0;
		@(posedge clock);
	endtask

	task automatic reportTest(input string name);
		repeat (2) @(posedge clock);
		testsRun = testsRun + 1;
		if (errorCount != errorsAtStart)
		begin
			testsFailed = testsFailed + 1;
			$display("%s: %0d errors", name, errorCount - errorsAtStart);
		end
		else
			$display("%s: ok", name);
		errorsAtStart = errorCount;
	endtask

	initial
	begin
		logic [5:0] mask;
		int         hold;
		reset = 1'b1;
		buttons = '0;
		void'($urandom(32'h3ba0));
		repeat (ResetCycles) @(posedge clock);
		reset <= 1'b0;

		repeat (40) @(posedge clock); // idle through one blank and one lit second
		reportTest("reset and expired flash");

		for (int i = 0; i < 6; i++)
		begin
			hold = $urandom_range(4, 1);
			pressButtons(6'b000001 << i, hold);
		end
		pressButtons(6'b000100, 6); // long hold adds once
		reportTest("single buttons");

		for (int i = 0; i < RandomPresses; i++)
		begin
			mask = 6'($urandom) & 6'b111100;
			if (mask == '0)
				mask = 6'b000100;
			hold = $urandom_range(3, 1);
			pressButtons(mask, hold);
			repeat ($urandom_range(2, 0)) @(posedge clock);
		end
		for (int i = 0; i < FillPresses; i++)
			pressButtons(6'b100000, 1); // pins the time at 99:59
		reportTest("random adds and saturation");

		pressButtons(6'b000001, 2);
		pressButtons(6'b000100, 1); // 01:15, borrows out of the minutes
		while (!expired)
			@(posedge clock);
		repeat (3 * TickClocks) @(posedge clock);
		pressOnPhase(6'b100000, 0); // both adds land between two ticks
		pressButtons(6'b100000, 1);
		repeat (TickClocks + 4) @(posedge clock); // 10:00 down to 09:59
		reportTest("countdown and expiry");

		pressButtons(6'b100000, 1);
		for (int phase = 13; phase <= 15; phase++)
			pressOnPhase(6'b000100, phase); // phase 14 meets the tick
		reportTest("request beats tick");

		for (int i = 0; i < SegmentRounds; i++)
		begin
			mask = ($urandom_range(1, 0) == 0) ? 6'b000001 : 6'b000010;
			pressButtons(mask, 1);
			repeat ($urandom_range(3, 0))
			begin
				mask = 6'b000100 << $urandom_range(3, 0);
				pressButtons(mask, 1);
			end
			repeat ($urandom_range(24, 1)) @(posedge clock);
		end
		reportTest("segment decode");

		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed,
			errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/bcdTimeKeeper.sv
`default_nettype none
`timescale 1ns/100ps

module bcdTimeKeeper (
	input  logic                   clock,
	input  logic                   reset,
	input  meterPkg::meterRequestT request,
	input  logic                   secondTick,
	output meterPkg::meterTimeT    remaining,
	output logic                   expired
);

	import meterPkg::*;

	////////////////////
	// digit helpers

	// returns {carryOut, digit}
	function automatic logic [4:0] addDigit(
		input bcdDigitT   a,
		input bcdDigitT   b,
		input logic       carryIn,
		input logic [4:0] radix
	);
		logic [4:0] sum;
		sum = 5'(a) + 5'(b) + 5'(carryIn);
		if (sum >= radix)
			return {1'b1, 4'(sum - radix)};
		else
			return {1'b0, sum[3:0]};
	endfunction

	// returns {borrowOut, digit}
	function automatic logic [4:0] subDigit(
		input bcdDigitT a,
		input logic     borrowIn,
		input bcdDigitT topDigit
	);
		if (borrowIn && a == 4'd0)
			return {1'b1, topDigit}; // wrap and pass the borrow on
		else
			return {1'b0, 4'(a - borrowIn)};
	endfunction

	////////////////////
	// next value

	meterTimeT sumTime;
	meterTimeT addedTime;
	meterTimeT decTime;
	meterTimeT nextTime;
	logic      secOnesCarry;
	logic      secTensCarry;
	logic      minOnesCarry;
	logic      minTensCarry;
	logic      secOnesBorrow;
	logic      secTensBorrow;
	logic      minOnesBorrow;
	logic      minTensBorrow;
	logic      isZero;

	assign isZero = (remaining == '0);

	// bcd add, seconds tens in base 6
	always_comb
	begin
		{secOnesCarry, sumTime.secOnes} =
			addDigit(remaining.secOnes, request.amount.secOnes, 1'b0, 5'd10);
		{secTensCarry, sumTime.secTens} =
			addDigit(remaining.secTens, request.amount.secTens, secOnesCarry, 5'd6);
		{minOnesCarry, sumTime.minOnes} =
			addDigit(remaining.minOnes, request.amount.minOnes, secTensCarry, 5'd10);
		{minTensCarry, sumTime.minTens} =
			addDigit(remaining.minTens, request.amount.minTens, minOnesCarry, 5'd10);
		addedTime = minTensCarry ? maxTime : sumTime; // saturate past 99:59
	end

	// one second down, only used when nonzero
	always_comb
	begin
		{secOnesBorrow, decTime.secOnes} = subDigit(remaining.secOnes, 1'b1, 4'd9);
		{secTensBorrow, decTime.secTens} = subDigit(remaining.secTens, secOnesBorrow, 4'd5);
		{minOnesBorrow, decTime.minOnes} = subDigit(remaining.minOnes, secTensBorrow, 4'd9);
		{minTensBorrow, decTime.minTens} = subDigit(remaining.minTens, minOnesBorrow, 4'd9);
	end

	// a request on a tick clock takes precedence and the tick is lost
	always_comb
	begin
		if (request.valid)
			nextTime = request.isPreset ? request.amount : addedTime;
		else if (secondTick && !isZero && !minTensBorrow)
			nextTime = decTime;
		else
			nextTime = remaining; // hold, 00:00 stays put
	end

	////////////////////
	// state

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			remaining <= '0;
			expired <= 1'b1;
		end
		else
		begin
			remaining <= nextTime;
			expired <= (nextTime == '0); // tracks remaining in the same cycle
		end
	end

endmodule

`default_nettype wire

// File: verilog/buttonEdges.sv
`default_nettype none
`timescale 1ns/100ps

module buttonEdges (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  addOne,
	input  logic                  addTwo,
	input  logic                  addThree,
	input  logic                  addFive,
	input  logic                  presetShortIn,
	input  logic                  presetLongIn,
	output meterPkg::meterRequestT request
);

	import meterPkg::*;

	logic [5:0] levels;     // index 0 has the highest priority
	logic [5:0] prevLevels;
	logic [5:0] rising;
	meterRequestT nextRequest;

	assign levels = {addFive, addThree, addTwo, addOne, presetLongIn, presetShortIn};
	assign rising = levels & ~prevLevels;

	// one request per edge, presets first
	always_comb
	begin
		nextRequest = '0;
		nextRequest.valid = |rising;
		if (rising[0])
		begin
			nextRequest.isPreset = 1'b1;
			nextRequest.amount = presetShort;
		end
		else if (rising[1])
		begin
			nextRequest.isPreset = 1'b1;
			nextRequest.amount = presetLong;
		end
		else if (rising[2])
			nextRequest.amount = addOneMinute;
		else if (rising[3])
			nextRequest.amount = addTwoMinutes;
		else if (rising[4])
			nextRequest.amount = addThreeMinutes;
		else if (rising[5])
			nextRequest.amount = addFiveMinutes;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			prevLevels <= '0;
			request <= '0;
		end
		else
		begin
			prevLevels <= levels;
			request <= nextRequest; // strobe lasts one clock
		end
	end

endmodule

`default_nettype wire

// File: verilog/meterPkg.sv
`default_nettype none

package meterPkg;

	////////////////////
	// digit and time types

	typedef logic [3:0] bcdDigitT; // one decimal digit, 0 to 9

	// most significant digit first
	typedef struct packed {
		bcdDigitT minTens;
		bcdDigitT minOnes;
		bcdDigitT secTens;
		bcdDigitT secOnes;
	} meterTimeT;

	// single-cycle strobe into the time keeper
	typedef struct packed {
		logic      valid;
		logic      isPreset; // load amount instead of adding it
		meterTimeT amount;
	} meterRequestT;

	////////////////////
	// display types

	typedef logic [6:0] segmentT; // active low, bit 6 is a, bit 0 is g

	typedef struct packed {
		segmentT minTens;
		segmentT minOnes;
		segmentT secTens;
		segmentT secOnes;
	} segmentBankT;

	localparam segmentT blankSegment = 7'b1111111; // all segments dark

	////////////////////
	// button amounts and limits

	localparam meterTimeT addOneMinute    = '{minTens: 4'd0, minOnes: 4'd1,
		secTens: 4'd0, secOnes: 4'd0};
	localparam meterTimeT addTwoMinutes   = '{minTens: 4'd0, minOnes: 4'd2,
		secTens: 4'd0, secOnes: 4'd0};
	localparam meterTimeT addThreeMinutes = '{minTens: 4'd0, minOnes: 4'd3,
		secTens: 4'd0, secOnes: 4'd0};
	localparam meterTimeT addFiveMinutes  = '{minTens: 4'd0, minOnes: 4'd5,
		secTens: 4'd0, secOnes: 4'd0};

	localparam meterTimeT presetShort = '{minTens: 4'd0, minOnes: 4'd0,
		secTens: 4'd1, secOnes: 4'd5}; // 00:15
	localparam meterTimeT presetLong  = '{minTens: 4'd0, minOnes: 4'd2,
		secTens: 4'd3, secOnes: 4'd0}; // 02:30

	localparam meterTimeT maxTime = '{minTens: 4'd9, minOnes: 4'd9,
		secTens: 4'd5, secOnes: 4'd9}; // 99:59 saturation point

	localparam int defaultSecondDivisor = 50000000; // 50 MHz board clock

endpackage

`default_nettype wire

// File: verilog/parkingMeter.sv
`default_nettype none
`timescale 1ns/100ps

module parkingMeter #(
	parameter int SecondDivisor = meterPkg::defaultSecondDivisor
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  addOne,
	input  logic                  addTwo,
	input  logic                  addThree,
	input  logic                  addFive,
	input  logic                  presetShortIn,
	input  logic                  presetLongIn,
	output meterPkg::meterTimeT   remaining,
	output logic                  expired,
	output meterPkg::segmentBankT segments
);

	import meterPkg::*;

	meterRequestT request;    // button strobe
	logic         secondTick;
	logic         flashPhase; // blink phase for the expired display

	buttonEdges buttonEdges_i (
		.clock         (clock),
		.reset         (reset),
		.addOne        (addOne),
		.addTwo        (addTwo),
		.addThree      (addThree),
		.addFive       (addFive),
		.presetShortIn (presetShortIn),
		.presetLongIn  (presetLongIn),
		.request       (request)
	);

	secondTicker #(
		.SecondDivisor (SecondDivisor)
	) secondTicker_i (
		.clock      (clock),
		.reset      (reset),
		.secondTick (secondTick),
		.flashPhase (flashPhase)
	);

	bcdTimeKeeper bcdTimeKeeper_i (
		.clock      (clock),
		.reset      (reset),
		.request    (request),
		.secondTick (secondTick),
		.remaining  (remaining),
		.expired    (expired)
	);

	segmentDriver segmentDriver_i (
		.remaining  (remaining),
		.expired    (expired),
		.flashPhase (flashPhase),
		.segments   (segments)
	);

endmodule

`default_nettype wire

// File: verilog/secondTicker.sv
`default_nettype none
`timescale 1ns/100ps

module secondTicker #(
	parameter int SecondDivisor = 50000000
) (
	input  logic clock,
	input  logic reset,
	output logic secondTick,
	output logic flashPhase
);

	localparam int CountWidth = (SecondDivisor > 1) ? $clog2(SecondDivisor) : 1;

	logic [CountWidth-1:0] count;
	logic                  wrap;

	assign wrap = (count == CountWidth'(SecondDivisor - 1));

	////////////////////
	// divider

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			count <= '0;
			secondTick <= 1'b0;
			flashPhase <= 1'b0;
		end
		else
		begin
			secondTick <= wrap; // one clock per second
			if (wrap)
			begin
				count <= '0;
				flashPhase <= ~flashPhase; // half-rate blink for the expired display
			end
			else
				count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/segmentDriver.sv
`default_nettype none
`timescale 1ns/100ps

module segmentDriver (
	input  meterPkg::meterTimeT   remaining,
	input  logic                  expired,
	input  logic                  flashPhase,
	output meterPkg::segmentBankT segments
);

	import meterPkg::*;

	// active-low pattern, a in bit 6
	function automatic segmentT decodeDigit(input bcdDigitT digit);
		case (digit)
			4'd0:    return 7'b0000001;
			4'd1:    return 7'b1001111;
			4'd2:    return 7'b0010010;
			4'd3:    return 7'b0000110;
			4'd4:    return 7'b1001100;
			4'd5:    return 7'b0100100;
			4'd6:    return 7'b0100000;
			4'd7:    return 7'b0001111;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0000100;
			default: return 7'b0000001; // bad codes show zero
		endcase
	endfunction

	logic blankNow;

	assign blankNow = expired && flashPhase; // flash while at 00:00

	always_comb
	begin
		if (blankNow)
		begin
			segments.minTens = blankSegment;
			segments.minOnes = blankSegment;
			segments.secTens = blankSegment;
			segments.secOnes = blankSegment;
		end
		else
		begin
			segments.minTens = decodeDigit(remaining.minTens);
			segments.minOnes = decodeDigit(remaining.minOnes);
			segments.secTens = decodeDigit(remaining.secTens);
			segments.secOnes = decodeDigit(remaining.secOnes);
		end
	end

endmodule

`default_nettype wire
